// ==== width_buffer_top.f ====
common/buf_pkg.sv
tiled_ram/asym_ram_tile.sv
tiled_ram/tiled_ram.sv
verilog/ingress_channel.sv
verilog/write_arbiter.sv
verilog/drain_engine.sv
verilog/width_buffer_top.sv
bench/width_buffer_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= width_buffer_tb
FILELIST  ?= width_buffer_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Test OK

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/width_buffer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module width_buffer_tb import buf_pkg::*; ();

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 8;
    localparam int N_WORDS      = 120;  // per channel
    localparam int STALL_START  = 100;  // cycles after reset
    localparam int STALL_CYCLES = 200;  // consumer holds all credits
    localparam int WORD_CYCLES  = 20;   // per-word latency bound
    localparam int IDLE_END     = 32;   // beat-free cycles that end the drain
    localparam int BOUND        = REGION_WORDS + INGRESS_DEPTH;
    localparam int LIMIT_NS     =
        (RESET_CYCLES + STALL_START + STALL_CYCLES + 2 * N_WORDS * WORD_CYCLES) * PERIOD;

    logic                  clk;
    logic                  reset;
    logic [N_CHANNELS-1:0] in_valid;
    word_t                 in_data [N_CHANNELS];
    logic [N_CHANNELS-1:0] src_credit;
    out_half_t             out;
    logic                  out_credit;

    integer                seed = 32'h7370;
    word_t                 sb [N_CHANNELS][$];  // sent words, oldest first
    int                    sb_left [N_CHANNELS];
    int                    sent [N_CHANNELS];
    int                    rcvd [N_CHANNELS];   // words whose high half came out
    int                    cred_pulses [N_CHANNELS];
    int                    src_cred [N_CHANNELS];  // credits held by each source
    logic                  hi_next [N_CHANNELS];
    logic [N_CHANNELS-1:0] at_bound;
    logic [N_CHANNELS-1:0] bound_hit;
    int                    beats;
    int                    returned;
    int                    owed;      // beats not yet paid back
    int                    cycle;
    int                    quiet;     // cycles without a beat once sending is over
    logic                  stalled;
    logic                  end_check;
    logic                  chk_valid;
    logic                  stray_beat;
    logic [HALF_W:0]       exp_beat;  // {hi, data}
    logic [HALF_W:0]       got_beat;
    chan_t                 chk_chan;

    width_buffer_top dut_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .src_credit (src_credit),
        .out        (out),
        .out_credit (out_credit)
    );

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    // compare each beat against the head of its channel's scoreboard
    task automatic check_output();
        chan_t c;
        word_t w;
        chk_valid  = 1'b0;
        stray_beat = 1'b0;
        if (out.valid) begin
            c = out.chan;
            beats++;
            owed++;
            if (sb[c].size() == 0) begin
                stray_beat = 1'b1;
            end else begin
                w         = sb[c][0];
                chk_valid = 1'b1;
                chk_chan  = c;
                exp_beat  = {hi_next[c], hi_next[c] ? w[WORD_W-1 -: HALF_W] : w[HALF_W-1:0]};
                got_beat  = {out.hi, out.data};
                if (hi_next[c]) begin
                    w = sb[c].pop_front();  // word complete
                    rcvd[c]++;
                end
                hi_next[c] = ~hi_next[c];
            end
        end
        for (int k = 0; k < N_CHANNELS; k++) begin
            sb_left[k] = sb[k].size();
        end
    endtask

    // sources only send while holding a credit
    task automatic drive_sources();
        for (int c = 0; c < N_CHANNELS; c++) begin
            if (src_credit[c]) begin
                src_cred[c]++;
                cred_pulses[c]++;
            end
            in_valid[c] = 1'b0;
            if (src_cred[c] > 0 && sent[c] < N_WORDS && ($random(seed) & 1) == 0) begin
                in_data[c]  = $random(seed);
                in_valid[c] = 1'b1;
                src_cred[c]--;
                sb[c].push_back(in_data[c]);
                sent[c]++;
            end
            at_bound[c] = (sent[c] - rcvd[c] == BOUND);
            if (stalled && at_bound[c]) begin
                bound_hit[c] = 1'b1;
            end
        end
    endtask

    // random credit return, none during the stall, all once sending ends
    task automatic drive_consumer();
        logic done_sending;
        done_sending = (sent[0] == N_WORDS) && (sent[1] == N_WORDS);
        out_credit   = 1'b0;
        if (owed > 0 && !stalled && (done_sending || ($random(seed) & 1) == 1)) begin
            out_credit = 1'b1;
            owed--;
            returned++;
        end
    endtask

    initial begin
        reset      = 1'b1;
        in_valid   = '0;
        out_credit = 1'b0;
        beats      = 0;
        returned   = 0;
        owed       = 0;
        cycle      = 0;
        quiet      = 0;
        stalled    = 1'b0;
        end_check  = 1'b0;
        chk_valid  = 1'b0;
        stray_beat = 1'b0;
        at_bound   = '0;
        bound_hit  = '0;
        for (int c = 0; c < N_CHANNELS; c++) begin
            in_data[c]     = '0;
            sent[c]        = 0;
            rcvd[c]        = 0;
            sb_left[c]     = 0;
            cred_pulses[c] = 0;
            src_cred[c]    = INGRESS_DEPTH;
            hi_next[c]     = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        // run until the output has gone silent after the last send
        while (quiet < IDLE_END) begin
            @(posedge clk);
            #1;  // outputs settled, inputs change here
            cycle++;
            stalled = (cycle >= STALL_START) && (cycle < STALL_START + STALL_CYCLES);
            check_output();
            drive_sources();
            drive_consumer();
            if (sent[0] == N_WORDS && sent[1] == N_WORDS && !stalled && !out.valid) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
        in_valid  = '0;
        end_check = 1'b1;  // final scoreboard state
        repeat (2) @(posedge clk);
        $display("Test OK");
        $finish;
    end

    initial begin
        #(LIMIT_NS);
        stop_on_error("watchdog expired before every word came out");
    end

    a_data_order: assert property (@(posedge clk) chk_valid |-> exp_beat == got_beat)
        else stop_on_error($sformatf("Fail data_order ch%0d: expected %h actual %h",
                                     chk_chan, exp_beat, got_beat));

    a_stray_beat: assert property (@(posedge clk) !stray_beat)
        else stop_on_error("output beat on a channel with no word outstanding");

    a_out_credit: assert property (@(posedge clk) beats <= OUT_CREDITS + returned)
        else stop_on_error("more output beats than credits granted");

    // registers already reset in the cycle sampled here
    a_reset_state: assert property (@(posedge clk) $past(reset) |->
        (!out.valid && src_credit == '0))
        else stop_on_error("output valid or source credit high around reset");

    for (genvar c = 0; c < N_CHANNELS; c++) begin : g_chk
        a_src_pulses: assert property (@(posedge clk) cred_pulses[c] <= sent[c])
            else stop_on_error($sformatf("more source credits than words on ch%0d", c));

        a_src_hold: assert property (@(posedge clk) src_cred[c] <= INGRESS_DEPTH)
            else stop_on_error($sformatf("source %0d holds too many credits", c));

        a_bp_bound: assert property (@(posedge clk) sent[c] - rcvd[c] <= BOUND)
            else stop_on_error($sformatf("ch%0d holds more words than ring plus queue", c));

        // full ring and queue, no credit may come back
        a_bp_stop: assert property (@(posedge clk) (stalled && at_bound[c]) |=> !src_credit[c])
            else stop_on_error($sformatf("source credit returned at the bound on ch%0d", c));

        a_complete: assert property (@(posedge clk) end_check |->
            (rcvd[c] == N_WORDS && sb_left[c] == 0))
            else stop_on_error($sformatf("Fail completeness ch%0d: expected %0d actual %0d",
                                         c, N_WORDS, rcvd[c]));

        a_bp_reached: assert property (@(posedge clk) end_check |-> bound_hit[c])
            else stop_on_error($sformatf("stall never filled ch%0d to its bound", c));
    end

endmodule

`default_nettype wire

// ==== verilog/width_buffer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module width_buffer_top import buf_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [N_CHANNELS-1:0] in_valid,
    input  word_t                 in_data [N_CHANNELS],
    output logic [N_CHANNELS-1:0] src_credit,
    output out_half_t             out,
    input  logic                  out_credit
);

    wr_req_t               req [N_CHANNELS];  // per-channel write requests
    logic [N_CHANNELS-1:0] grant;
    logic [N_CHANNELS-1:0] done_vec;          // word_done steered per channel
    wr_bus_t               wr;                // shared ram write port
    logic                  r_en;
    raddr_t                r_addr;
    half_t                 r_data;
    logic                  word_done;
    chan_t                 done_chan;

    for (genvar c = 0; c < N_CHANNELS; c++) begin : g_chan
        assign done_vec[c] = word_done && (done_chan == chan_t'(c));

        ingress_channel #(
            .CHAN_ID (c)
        ) ingress_i (
            .clk        (clk),
            .reset      (reset),
            .in_valid   (in_valid[c]),
            .in_data    (in_data[c]),
            .grant      (grant[c]),
            .word_done  (done_vec[c]),
            .src_credit (src_credit[c]),
            .req        (req[c])
        );
    end

    write_arbiter arb_i (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .grant (grant),
        .wr    (wr)
    );

    tiled_ram ram_i (
        .clk    (clk),
        .wr     (wr),
        .r_en   (r_en),
        .r_addr (r_addr),
        .r_data (r_data)
    );

    drain_engine drain_i (
        .clk        (clk),
        .reset      (reset),
        .wr         (wr),
        .out_credit (out_credit),
        .r_en       (r_en),
        .r_addr     (r_addr),
        .r_data     (r_data),
        .out        (out),
        .word_done  (word_done),
        .done_chan  (done_chan)
    );

endmodule

`default_nettype wire

// ==== verilog/drain_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module drain_engine import buf_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  wr_bus_t   wr,
    input  logic      out_credit,
    output logic      r_en,
    output raddr_t    r_addr,
    input  half_t     r_data,
    output out_half_t out,
    output logic      word_done,
    output chan_t     done_chan
);

    drain_state_t          state;
    chan_t                 cur;              // channel in service, also rr pointer
    occ_t                  wr_cnt [N_CHANNELS];  // words written, wraps
    occ_t                  rd_cnt [N_CHANNELS];  // words drained, wraps
    logic [N_CHANNELS-1:0] pending;
    logic [CRED_W-1:0]     cred;
    logic                  has_cred;
    logic                  pick_ok;
    chan_t                 pick;
    logic                  issue_hi;         // upper half read this cycle
    logic                  out_valid_q;
    chan_t                 out_chan_q;
    logic                  out_hi_q;

    // modular difference, extra bit keeps full apart from empty
    always_comb begin
        for (int c = 0; c < N_CHANNELS; c++) begin
            pending[c] = (wr_cnt[c] != rd_cnt[c]);
        end
    end

    // round robin over non-empty channels
    always_comb begin
        int unsigned idx;
        pick_ok = 1'b0;
        pick    = cur;
        for (int k = 1; k <= N_CHANNELS; k++) begin
            idx = (int'(cur) + k) % N_CHANNELS;
            if (!pick_ok && pending[idx]) begin
                pick_ok = 1'b1;
                pick    = chan_t'(idx);
            end
        end
    end

    assign has_cred = (cred != '0);
    assign r_en     = has_cred && (state == READ_LO || state == READ_HI);
    assign issue_hi = has_cred && (state == READ_HI);
    // region base is the channel, lsb is the half
    assign r_addr   = {cur, rd_cnt[cur][REGION_W-1:0], state == READ_HI};

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            cur         <= chan_t'(N_CHANNELS - 1);
            cred        <= CRED_W'(OUT_CREDITS);
            out_valid_q <= 1'b0;
            word_done   <= 1'b0;
            for (int c = 0; c < N_CHANNELS; c++) begin
                wr_cnt[c] <= '0;
                rd_cnt[c] <= '0;
            end
        end else begin
            cred        <= cred + CRED_W'(out_credit) - CRED_W'(r_en);  // beat spends one
            out_valid_q <= r_en;
            word_done   <= issue_hi;  // reported as the high half leaves
            if (wr.en) begin
                wr_cnt[wr.chan] <= wr_cnt[wr.chan] + 1'b1;
            end
            case (state)
                IDLE: begin
                    if (pick_ok) begin
                        cur   <= pick;
                        state <= READ_LO;
                    end
                end
                READ_LO: if (has_cred) state <= READ_HI;  // stall here without credit
                READ_HI: begin
                    if (has_cred) begin
                        rd_cnt[cur] <= rd_cnt[cur] + 1'b1;
                        state       <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // beat tags follow the read by one cycle
    always_ff @(posedge clk) begin
        out_chan_q <= cur;
        out_hi_q   <= issue_hi;
        done_chan  <= cur;
    end

    // ram data arrives the cycle after r_en
    assign out = '{valid: out_valid_q, chan: out_chan_q, data: r_data, hi: out_hi_q};

    a_cred_max: assert property (@(posedge clk) disable iff (reset)
        cred <= OUT_CREDITS);

    // every beat took one credit off the counter
    a_valid_spent: assert property (@(posedge clk) disable iff (reset)
        (out.valid && !$past(out_credit)) |-> (int'(cred) == int'($past(cred)) - 1));

endmodule

`default_nettype wire

// ==== verilog/write_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module write_arbiter import buf_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  wr_req_t               req [N_CHANNELS],
    output logic [N_CHANNELS-1:0] grant,
    output wr_bus_t               wr
);

    chan_t last;   // last channel served
    chan_t sel;    // winner this cycle
    logic  found;  // any request granted

    // search starts one past the last winner
    always_comb begin
        int unsigned idx;
        grant = '0;
        sel   = last;
        found = 1'b0;
        for (int k = 1; k <= N_CHANNELS; k++) begin
            idx = (int'(last) + k) % N_CHANNELS;
            if (!found && req[idx].req) begin
                grant[idx] = 1'b1;
                sel        = chan_t'(idx);
                found      = 1'b1;
            end
        end
    end

    // winner onto the shared write port, tagged with its channel
    assign wr = '{en: found, chan: sel, addr: req[sel].addr, data: req[sel].data};

    always_ff @(posedge clk) begin
        if (reset) begin
            last <= chan_t'(N_CHANNELS - 1);  // channel 0 goes first
        end else if (found) begin
            last <= sel;
        end
    end

    a_grant_onehot0: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grant));

endmodule

`default_nettype wire

// ==== verilog/ingress_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

module ingress_channel import buf_pkg::*; #(
    parameter int CHAN_ID = 0  // selects the owned ram region
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    in_valid,
    input  word_t   in_data,
    input  logic    grant,
    input  logic    word_done,
    output logic    src_credit,
    output wr_req_t req
);

    word_t               q_mem [INGRESS_DEPTH];  // input queue storage
    logic [Q_PTR_W-1:0]  q_wp;
    logic [Q_PTR_W-1:0]  q_rp;
    logic [Q_CNT_W-1:0]  q_cnt;    // queued words
    logic [REGION_W-1:0] ring_wp;  // next slot inside the region
    occ_t                occ;      // words in ram not yet drained

    // queue payload
    always_ff @(posedge clk) begin
        if (in_valid) begin
            q_mem[q_wp] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            q_wp       <= '0;
            q_rp       <= '0;
            q_cnt      <= '0;
            ring_wp    <= '0;
            occ        <= '0;
            src_credit <= 1'b0;
        end else begin
            src_credit <= grant;  // one credit back per word moved to ram
            if (in_valid) begin
                q_wp <= q_wp + 1'b1;
            end
            if (grant) begin
                q_rp    <= q_rp + 1'b1;
                ring_wp <= ring_wp + 1'b1;  // region size is a power of two, wraps
            end
            case ({in_valid, grant})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;
            endcase
            // written word in, fully drained word out
            case ({grant, word_done})
                2'b10:   occ <= occ + 1'b1;
                2'b01:   occ <= occ - 1'b1;
                default: occ <= occ;
            endcase
        end
    end

    // request only with data queued and room left in the region
    assign req.req  = (q_cnt != '0) && (occ < REGION_WORDS);
    assign req.addr = {chan_t'(CHAN_ID), ring_wp};  // region base is the channel id
    assign req.data = q_mem[q_rp];

    // source must not send without a credit
    a_no_push_full: assert property (@(posedge clk) disable iff (reset)
        in_valid |-> (q_cnt < INGRESS_DEPTH));

    // drain reports must keep pace with writes
    a_occ_bound: assert property (@(posedge clk) disable iff (reset)
        occ <= REGION_WORDS);

endmodule

`default_nettype wire

// ==== tiled_ram/tiled_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module tiled_ram import buf_pkg::*; (
    input  logic    clk,
    input  wr_bus_t wr,
    input  logic    r_en,
    input  raddr_t  r_addr,
    output half_t   r_data
);

    logic [TILE_SEL_W-1:0] w_tile;     // tile addressed by the write
    logic [TILE_SEL_W-1:0] r_tile;     // tile addressed by the read
    logic [TILE_SEL_W-1:0] r_tile_q;   // read tile, aligned with tile output
    logic [N_TILES-1:0]    w_tile_en;
    logic [N_TILES-1:0]    r_tile_en;
    half_t                 r_data_vec [N_TILES];

    // one-hot decode of a tile number
    function automatic logic [N_TILES-1:0] tile_dec(input logic [TILE_SEL_W-1:0] sel);
        logic [N_TILES-1:0] dec;
        dec      = '0;
        dec[sel] = 1'b1;
        return dec;
    endfunction

    assign w_tile    = wr.addr[WADDR_W-1 -: TILE_SEL_W];  // msbs pick the tile
    assign r_tile    = r_addr[RADDR_W-1 -: TILE_SEL_W];
    assign w_tile_en = tile_dec(w_tile);
    assign r_tile_en = tile_dec(r_tile);

    // tile bank
    for (genvar t = 0; t < N_TILES; t++) begin : g_tile
        asym_ram_tile tile_i (
            .clk    (clk),
            .w_en   (wr.en & w_tile_en[t]),
            .w_addr (wr.addr[TILE_WADDR_W-1:0]),
            .w_data (wr.data),
            .r_en   (r_en & r_tile_en[t]),
            .r_addr (r_addr[TILE_RADDR_W-1:0]),
            .r_data (r_data_vec[t])
        );
    end

    // tile outputs lag one cycle, so the select must too
    always_ff @(posedge clk) begin
        if (r_en) begin
            r_tile_q <= r_tile;
        end
    end

    // only the last-read tile holds fresh data
    assign r_data = r_data_vec[r_tile_q];

    // exactly one tile takes each write
    a_wr_onehot: assert property (@(posedge clk) wr.en |-> $onehot(w_tile_en));

endmodule

`default_nettype wire

// ==== tiled_ram/asym_ram_tile.sv ====
`timescale 1ns/1ps
`default_nettype none

module asym_ram_tile import buf_pkg::*; (
    input  logic                    clk,
    input  logic                    w_en,
    input  logic [TILE_WADDR_W-1:0] w_addr,
    input  word_t                   w_data,
    input  logic                    r_en,
    input  logic [TILE_RADDR_W-1:0] r_addr,
    output half_t                   r_data
);

    word_t mem [TILE_WORDS];  // full words, split only on read
    word_t rd_word;           // word addressed by the read port

    // write side, one full word per edge
    always_ff @(posedge clk) begin
        if (w_en) begin
            mem[w_addr] <= w_data;
        end
    end

    // upper bits of the half address select the word
    assign rd_word = mem[r_addr[TILE_RADDR_W-1:1]];

    // lsb picks the half, result registered
    // a same-edge write is not visible until the next read
    always_ff @(posedge clk) begin
        if (r_en) begin
            if (r_addr[0]) begin
                r_data <= rd_word[WORD_W-1 -: HALF_W];  // high half
            end else begin
                r_data <= rd_word[HALF_W-1:0];          // low half
            end
        end
    end

endmodule

`default_nettype wire

// ==== common/buf_pkg.sv ====
`default_nettype none

package buf_pkg;

    // datapath widths
    localparam int WORD_W = 32;  // write side
    localparam int HALF_W = 16;  // read side

    // channel and memory sizing
    localparam int N_CHANNELS    = 2;
    localparam int RAM_WORDS     = 64;
    localparam int TILE_WORDS    = 16;
    localparam int N_TILES       = RAM_WORDS / TILE_WORDS;
    localparam int REGION_WORDS  = RAM_WORDS / N_CHANNELS;  // ring size per channel
    localparam int INGRESS_DEPTH = 2;  // queue entries, also initial source credits
    localparam int OUT_CREDITS   = 4;  // consumer credits at reset

    // derived address widths
    localparam int CHAN_W       = $clog2(N_CHANNELS);
    localparam int WADDR_W      = $clog2(RAM_WORDS);
    localparam int RADDR_W      = WADDR_W + 1;  // one more bit picks the half
    localparam int TILE_WADDR_W = $clog2(TILE_WORDS);
    localparam int TILE_RADDR_W = TILE_WADDR_W + 1;
    localparam int TILE_SEL_W   = $clog2(N_TILES);
    localparam int REGION_W     = $clog2(REGION_WORDS);
    localparam int Q_PTR_W      = $clog2(INGRESS_DEPTH);
    localparam int Q_CNT_W      = $clog2(INGRESS_DEPTH + 1);
    localparam int CRED_W       = $clog2(OUT_CREDITS + 1);

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [HALF_W-1:0]  half_t;
    typedef logic [WADDR_W-1:0] waddr_t;
    typedef logic [RADDR_W-1:0] raddr_t;
    typedef logic [CHAN_W-1:0]  chan_t;
    typedef logic [REGION_W:0]  occ_t;  // 0..REGION_WORDS inclusive

    // ingress channel -> arbiter
    typedef struct packed {
        logic   req;
        waddr_t addr;
        word_t  data;
    } wr_req_t;

    // arbitrated ram write, also watched by the drain side
    typedef struct packed {
        logic   en;
        chan_t  chan;
        waddr_t addr;
        word_t  data;
    } wr_bus_t;

    // one output beat
    typedef struct packed {
        logic  valid;
        chan_t chan;
        half_t data;
        logic  hi;  // set on the upper half of a word
    } out_half_t;

    typedef enum logic [1:0] {
        IDLE,
        READ_LO,
        READ_HI
    } drain_state_t;

endpackage

`default_nettype wire
